// ==== design/mio_cfg_pkg.sv ====
// link configuration
// widths and channel count of the transmit link

package mio_cfg_pkg;

   // ####################
   // io side
   // one IO half in bits
   localparam int io_w = 16;
   // a core packet is two halves
   localparam int pkt_w = 2 * io_w;

   // ####################
   // core side
   // number of peer transmit channels
   localparam int num_ch = 2;
   // bits for a channel index
   localparam int ch_id_w = 1;

endpackage

// ==== design/mio_link_pkg.sv ====
// link types
// packet layout and the arbiter request to the io block

package mio_link_pkg;

   // ####################
   // core packet
   // hi goes out first in sdr mode
   typedef struct packed {
      logic [mio_cfg_pkg::io_w-1:0] hi;
      logic [mio_cfg_pkg::io_w-1:0] lo;
   } mio_packet_t;

   // ####################
   // io request
   // held stable by the arbiter while io_wait is high
   typedef struct packed {
      // request valid
      logic                            access;
      // word to send
      mio_packet_t                     packet;
      // channel the word came from
      logic [mio_cfg_pkg::ch_id_w-1:0] src;
   } mtx_req_t;

endpackage

// ==== design/mtx_channel.sv ====
`timescale 1ns/1ps
// transmit channel
// one-entry packet buffer between a core channel and the arbiter

module mtx_channel (
   input  logic                      io_clk,
   input  logic                      io_nreset,
   input  logic                      in_access,
   input  mio_link_pkg::mio_packet_t in_packet,
   input  logic                      pop,
   output logic                      in_wait,
   output logic                      full,
   output mio_link_pkg::mio_packet_t held
);

   // ####################
   // occupancy
   // set by a core strobe, cleared when the arbiter pops
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         full <= 1'b0;
      end else if (in_access) begin
         full <= 1'b1;
      end else if (pop) begin
         full <= 1'b0;
      end
   end

   // core sees the buffer state directly
   // wait drops the cycle after the pop
   assign in_wait = full;

   // ####################
   // payload
   // no reset, only valid while full
   always_ff @(posedge io_clk) begin
      if (in_access) begin
         held <= in_packet;
      end
   end

   // ####################
   // checks
   // core must respect in_wait
   a_no_load_when_full : assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      in_access |-> !full
   ) else $error("mtx_channel: strobe while full");

   // arbiter only consumes a word it was shown
   a_no_pop_when_empty : assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      pop |-> full
   ) else $error("mtx_channel: pop while empty");

endmodule

// ==== design/mtx_arbiter.sv ====
`timescale 1ns/1ps
// transmit arbiter
// round-robin selection of a full channel onto the io request bus

module mtx_arbiter (
   input  logic                                                io_clk,
   input  logic                                                io_nreset,
   input  logic [mio_cfg_pkg::num_ch-1:0]                      full,
   input  mio_link_pkg::mio_packet_t [mio_cfg_pkg::num_ch-1:0] held,
   input  logic                                                io_wait,
   output logic [mio_cfg_pkg::num_ch-1:0]                      pop,
   output mio_link_pkg::mtx_req_t                              io_req
);
   import mio_cfg_pkg::*;

   logic [ch_id_w-1:0] ptr;
   logic [ch_id_w-1:0] sel;
   logic [ch_id_w-1:0] lock_src;
   logic [ch_id_w-1:0] ptr_next;
   logic               lock;
   logic               found;
   logic               consume;

   // ####################
   // selection
   // a stalled request stays locked to its source
   // otherwise first full channel from the pointer wins
   always_comb begin
      int unsigned cand;
      cand  = 0;
      sel   = ptr;
      found = 1'b0;
      if (lock) begin
         sel   = lock_src;
         found = full[lock_src];
      end else begin
         for (int k = 0; k < num_ch; k++) begin
            cand = (int'(ptr) + k) % num_ch;
            if (!found && full[cand]) begin
               sel   = ch_id_w'(cand);
               found = 1'b1;
            end
         end
      end
   end

   // request straight from the buffers
   assign io_req.access = found;
   assign io_req.packet = held[sel];
   assign io_req.src    = sel;

   // word leaves when the io block stops pushing back
   assign consume = io_req.access & ~io_wait;

   // one-cycle pop to the source channel
   always_comb begin
      pop      = '0;
      pop[sel] = consume;
   end

   // wrap past the last channel
   assign ptr_next = (sel == ch_id_w'(num_ch - 1)) ? '0 : sel + 1'b1;

   // ####################
   // pointer and lock
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         ptr      <= '0;
         lock     <= 1'b0;
         lock_src <= '0;
      end else begin
         // move past the consumed source
         if (consume) begin
            ptr <= ptr_next;
         end
         // pending but stalled, freeze the choice
         lock <= io_req.access & io_wait;
         if (io_req.access && io_wait) begin
            lock_src <= sel;
         end
      end
   end

   // ####################
   // checks
   // a stalled request must not change under the io block
   a_req_stable : assert property (
      @(posedge io_clk) disable iff (!io_nreset)
      (io_req.access && io_wait) |=> $stable(io_req)
   ) else $error("mtx_arbiter: io_req changed while io_wait high");

endmodule

// ==== design/oh_oddr.sv ====
`timescale 1ns/1ps
// output ddr register
// din1 shown in the clock high phase, din2 in the low phase

module oh_oddr (
   input  logic                         clk,
   input  logic                         ce,
   input  logic [mio_cfg_pkg::io_w-1:0] din1,
   input  logic [mio_cfg_pkg::io_w-1:0] din2,
   output logic [mio_cfg_pkg::io_w-1:0] out
);
   import mio_cfg_pkg::*;

   logic [io_w-1:0] q1;
   logic [io_w-1:0] q2;
   logic [io_w-1:0] q2_neg;

   // ####################
   // rising edge capture
   always_ff @(posedge clk) begin
      if (ce) begin
         q1 <= din1;
         q2 <= din2;
      end
   end

   // second half moves to the falling edge
   // so it is stable through the low phase
   always_ff @(negedge clk) begin
      q2_neg <= q2;
   end

   // clock picks the phase
   assign out = clk ? q1 : q2_neg;

endmodule

// ==== design/mtx_io.sv ====
`timescale 1ns/1ps
// transmit io block
// sends each packet as two halves, sdr over two cycles or ddr in one

module mtx_io (
   input  logic                         io_clk,
   input  logic                         io_nreset,
   input  logic                         ddr_mode,
   input  logic                         tx_wait,
   input  mio_link_pkg::mtx_req_t       io_req,
   output logic                         io_wait,
   output logic [mio_cfg_pkg::io_w-1:0] tx_packet,
   output logic                         tx_access
);
   import mio_cfg_pkg::*;

   logic [1:0]       rsync;
   logic             io_rst_n;
   logic [pkt_w-1:0] req_word;
   logic [io_w-1:0]  sdr_half;
   logic [io_w-1:0]  tx_packet_sdr;
   logic [io_w-1:0]  tx_packet_ddr;
   logic             half_sel;
   logic             fresh;

   // ####################
   // reset
   // async assert, release after two io clocks
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         rsync <= 2'b00;
      end else begin
         rsync <= {rsync[0], 1'b1};
      end
   end

   assign io_rst_n = rsync[1];

   // ####################
   // sdr half select
   // 0 for hi, 1 for lo, frozen while the pins push back
   always_ff @(posedge io_clk or negedge io_rst_n) begin
      if (!io_rst_n) begin
         half_sel <= 1'b0;
      end else if (tx_wait) begin
         half_sel <= half_sel;
      end else if (ddr_mode || !io_req.access) begin
         half_sel <= 1'b0;
      end else begin
         half_sel <= ~half_sel;
      end
   end

   // hold the word during its hi half
   // so it is only consumed on the lo half
   assign io_wait = tx_wait | (~ddr_mode & io_req.access & ~half_sel);

   // half picked out of the flat word
   assign req_word = io_req.packet;
   assign sdr_half = half_sel ? req_word[io_w-1:0] : req_word[pkt_w-1:io_w];

   // a half goes out whenever the pins accept one
   assign fresh = io_req.access & ~tx_wait;

   // sdr data register
   always_ff @(posedge io_clk) begin
      if (fresh) begin
         tx_packet_sdr <= sdr_half;
      end
   end

   // ####################
   // access strobe
   // high only for a newly sampled half or word
   always_ff @(posedge io_clk or negedge io_rst_n) begin
      if (!io_rst_n) begin
         tx_access <= 1'b0;
      end else begin
         tx_access <= fresh;
      end
   end

   // ####################
   // ddr path
   // lo in the high phase, hi in the low phase
   oh_oddr data_oddr (
      .clk  (io_clk),
      .ce   (fresh),
      .din1 (io_req.packet.lo),
      .din2 (io_req.packet.hi),
      .out  (tx_packet_ddr)
   );

   // output format by mode
   assign tx_packet = ddr_mode ? tx_packet_ddr : tx_packet_sdr;

   // ####################
   // checks
   // lo half is only reached from an active request
   a_half_sel_origin : assert property (
      @(posedge io_clk) disable iff (!io_rst_n)
      !$past(io_req.access) |-> !half_sel
   ) else $error("mtx_io: half select set without a prior request");

endmodule

// ==== design/mtx_top.sv ====
`timescale 1ns/1ps
// transmit top
// core channels share one io serializer through a round-robin arbiter

module mtx_top (
   input  logic                                                io_clk,
   input  logic                                                io_nreset,
   input  logic                                                ddr_mode,
   input  logic                                                tx_wait,
   input  logic [mio_cfg_pkg::num_ch-1:0]                      in_access,
   input  mio_link_pkg::mio_packet_t [mio_cfg_pkg::num_ch-1:0] in_packet,
   output logic [mio_cfg_pkg::num_ch-1:0]                      in_wait,
   output logic [mio_cfg_pkg::io_w-1:0]                        tx_packet,
   output logic                                                tx_access
);
   import mio_cfg_pkg::*;
   import mio_link_pkg::*;

   logic [num_ch-1:0]              full;
   logic [num_ch-1:0]              pop;
   mio_packet_t [num_ch-1:0]       held;
   mtx_req_t                       io_req;
   logic                           io_wait;

   // ####################
   // core channels
   for (genvar i = 0; i < num_ch; i++) begin : ch
      mtx_channel chan0 (
         .io_clk    (io_clk),
         .io_nreset (io_nreset),
         .in_access (in_access[i]),
         .in_packet (in_packet[i]),
         .pop       (pop[i]),
         .in_wait   (in_wait[i]),
         .full      (full[i]),
         .held      (held[i])
      );
   end

   // ####################
   // arbiter
   mtx_arbiter arb0 (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .full      (full),
      .held      (held),
      .io_wait   (io_wait),
      .pop       (pop),
      .io_req    (io_req)
   );

   // ####################
   // io serializer
   mtx_io io0 (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .ddr_mode  (ddr_mode),
      .tx_wait   (tx_wait),
      .io_req    (io_req),
      .io_wait   (io_wait),
      .tx_packet (tx_packet),
      .tx_access (tx_access)
   );

endmodule

// ==== testbench/mtx_tb.sv ====
`timescale 1ns/1ps
// transmit link testbench
// table-driven stimulus checked against a word-level model of the link

module mtx_tb;
   import mio_cfg_pkg::*;
   import mio_link_pkg::*;

   localparam int clk_period   = 40;
   localparam int n_rows       = 13;
   localparam int watch_cycles = n_rows * 20 + 50;

   // one stimulus row
   typedef struct packed {
      // channel index, 2 loads both at once
      logic [1:0]  chan;
      logic        rnd;
      mio_packet_t pkt;
      logic        ddr;
      // random tx_wait pulses during the row
      logic        wpulse;
      // strobe to tx_access latency check
      logic        lat;
      logic [3:0]  gap;
   } row_t;

   // expected word with its source channel
   typedef struct packed {
      mio_packet_t        pkt;
      logic [ch_id_w-1:0] src;
   } exp_word_t;

   logic                      io_clk = 1'b0;
   logic                      io_nreset;
   logic                      ddr_mode;
   logic                      tx_wait;
   logic [num_ch-1:0]         in_access;
   mio_packet_t [num_ch-1:0]  in_packet;
   logic [num_ch-1:0]         in_wait;
   logic [io_w-1:0]           tx_packet;
   logic                      tx_access;

   row_t                      rows [n_rows];
   exp_word_t                 exp_q [$];
   exp_word_t                 mon_w;
   logic [ch_id_w-1:0]        ptr_m = '0;
   logic                      wait_en = 1'b0;
   logic                      seen_wait;
   logic                      half_idx = 1'b0;
   logic                      lat_pend = 1'b0;
   int                        lat_cycle = 0;
   int                        cyc = 0;
   int                        seed;
   int                        val_errs = 0;
   int                        other_errs = 0;

   mtx_top dut0 (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .ddr_mode  (ddr_mode),
      .tx_wait   (tx_wait),
      .in_access (in_access),
      .in_packet (in_packet),
      .in_wait   (in_wait),
      .tx_packet (tx_packet),
      .tx_access (tx_access)
   );

   always #(clk_period / 2) io_clk = ~io_clk;

   // ####################
   // helpers
   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         val_errs++;
         $display("[FAIL] %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   function automatic row_t make_row(input logic [1:0] chan, input logic rnd,
                                     input logic [31:0] pkt, input logic ddr,
                                     input logic wpulse, input logic lat, input int gap);
      row_t r;
      r.chan   = chan;
      r.rnd    = rnd;
      r.pkt    = pkt;
      r.ddr    = ddr;
      r.wpulse = wpulse;
      r.lat    = lat;
      r.gap    = 4'(gap);
      return r;
   endfunction

   // next falling edge, pins pushback drawn here
   task automatic step();
      @(negedge io_clk);
      tx_wait = wait_en ? (($random(seed) & 3) == 0) : 1'b0;
   endtask

   // model side, pointer moves past the source
   task automatic push_word(input logic [ch_id_w-1:0] c, input mio_packet_t p);
      exp_word_t w;
      w.pkt = p;
      w.src = c;
      exp_q.push_back(w);
      ptr_m = ch_id_w'((int'(c) + 1) % num_ch);
   endtask

   task automatic apply_row(input row_t r);
      mio_packet_t        pk [num_ch];
      logic [ch_id_w-1:0] c;
      c       = r.chan[ch_id_w-1:0];
      wait_en = r.wpulse;
      if (r.rnd) begin
         pk[0] = mio_packet_t'($random(seed));
         pk[1] = mio_packet_t'($random(seed));
      end else begin
         pk[0] = r.pkt;
         pk[1] = mio_packet_t'(~r.pkt);
      end
      // mode changes and latency rows need an idle link
      if (r.lat || r.ddr != ddr_mode) begin
         while (exp_q.size() != 0) step();
         step();
         step();
         ddr_mode = r.ddr;
      end
      if (r.chan == 2'd2) begin
         while (in_wait != '0) step();
         for (int k = 0; k < num_ch; k++) in_packet[k] = pk[k];
         in_access = '1;
         // both full, order from the pointer
         repeat (num_ch) push_word(ptr_m, pk[ptr_m]);
      end else begin
         while (in_wait[c]) step();
         in_packet[c] = pk[0];
         in_access[c] = 1'b1;
         push_word(c, pk[0]);
      end
      if (r.lat) begin
         lat_cycle = cyc;
         lat_pend  = 1'b1;
      end
      step();
      in_access = '0;
      repeat (r.gap) step();
   endtask

   task automatic finish_run();
      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   // ####################
   // output monitor
   // sdr halves and ddr lo sampled in the high phase, ddr hi in the low phase
   always @(posedge io_clk) begin
      seen_wait = tx_wait;
      cyc++;
      #5;
      if (seen_wait === 1'b1) check("tx_access after tx_wait", tx_access, 0);
      if (tx_access === 1'b1) begin
         if (exp_q.size() == 0) begin
            other_errs++;
            $display("tx_access high at %0t ns with no word outstanding", $time);
         end else if (ddr_mode) begin
            mon_w = exp_q.pop_front();
            check("in_wait", in_wait[mon_w.src], 0);
            check("tx_packet lo", tx_packet, mon_w.pkt.lo);
            if (lat_pend) begin
               check("tx_access latency", cyc - lat_cycle, 2);
               lat_pend = 1'b0;
            end
            @(negedge io_clk);
            #5;
            check("tx_packet hi", tx_packet, mon_w.pkt.hi);
         end else if (!half_idx) begin
            mon_w = exp_q[0];
            check("tx_packet hi", tx_packet, mon_w.pkt.hi);
            if (lat_pend) check("tx_access latency", cyc - lat_cycle, 2);
            half_idx = 1'b1;
         end else begin
            // word consumed on its lo half
            mon_w = exp_q.pop_front();
            check("in_wait", in_wait[mon_w.src], 0);
            check("tx_packet lo", tx_packet, mon_w.pkt.lo);
            if (lat_pend) begin
               check("tx_access latency", cyc - lat_cycle, 3);
               lat_pend = 1'b0;
            end
            half_idx = 1'b0;
         end
      end
   end

   // ####################
   // main sequence
   initial begin
      seed      = 64529;
      io_nreset = 1'b0;
      ddr_mode  = 1'b0;
      tx_wait   = 1'b0;
      in_access = '0;
      in_packet = '0;
      // sdr singles, ddr runs, round robin, pushback, mode switch back
      rows[0]  = make_row(2'd0, 1'b0, 32'ha1b2_c3d4, 1'b0, 1'b0, 1'b1, 4);
      rows[1]  = make_row(2'd1, 1'b0, 32'h1122_3344, 1'b0, 1'b0, 1'b1, 2);
      rows[2]  = make_row(2'd0, 1'b0, 32'h5566_7788, 1'b1, 1'b0, 1'b1, 0);
      rows[3]  = make_row(2'd0, 1'b1, 32'h0, 1'b1, 1'b0, 1'b0, 0);
      rows[4]  = make_row(2'd0, 1'b1, 32'h0, 1'b1, 1'b0, 1'b0, 0);
      rows[5]  = make_row(2'd2, 1'b0, 32'hcafe_f00d, 1'b1, 1'b0, 1'b0, 2);
      rows[6]  = make_row(2'd2, 1'b1, 32'h0, 1'b0, 1'b0, 1'b0, 1);
      rows[7]  = make_row(2'd1, 1'b1, 32'h0, 1'b0, 1'b1, 1'b0, 0);
      rows[8]  = make_row(2'd0, 1'b1, 32'h0, 1'b0, 1'b1, 1'b0, 0);
      rows[9]  = make_row(2'd2, 1'b1, 32'h0, 1'b0, 1'b1, 1'b0, 0);
      rows[10] = make_row(2'd1, 1'b1, 32'h0, 1'b1, 1'b1, 1'b0, 0);
      rows[11] = make_row(2'd2, 1'b1, 32'h0, 1'b1, 1'b1, 1'b0, 3);
      rows[12] = make_row(2'd0, 1'b0, 32'h0f0f_f0f0, 1'b0, 1'b0, 1'b1, 2);
      repeat (4) @(negedge io_clk);
      io_nreset = 1'b1;
      // let the io reset synchronizer release
      repeat (3) step();
      check("tx_access", tx_access, 0);
      check("in_wait", in_wait, 0);
      for (int k = 0; k < n_rows; k++) apply_row(rows[k]);
      wait_en = 1'b0;
      while (exp_q.size() != 0) step();
      repeat (4) step();
      finish_run();
   end

   // ####################
   // watchdog
   initial begin
      #(clk_period * watch_cycles);
      other_errs++;
      $display("timeout: run did not finish within %0d clock periods", watch_cycles);
      finish_run();
   end

endmodule

// ==== sources.f ====
design/mio_cfg_pkg.sv
design/mio_link_pkg.sv
design/mtx_channel.sv
design/mtx_arbiter.sv
design/oh_oddr.sv
design/mtx_io.sv
design/mtx_top.sv
testbench/mtx_tb.sv

// ==== Makefile ====
TOP := mtx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
